// File: hw/gpioPkg.sv
//--------------------------------------------------------------------------
// GPIO LED controller shared definitions
// Register offsets, field widths, flash mode codes and reset values
// used by the register block and the LED channels
//--------------------------------------------------------------------------
`default_nettype none

package gpioPkg;

	// Channel count is fixed by the register map
	localparam int cLedNumber = 5;

	// Field widths
	localparam int cFlashModeWidth = 2;
	localparam int cDutyWidth = 8;
	localparam int cIvTimerWidth = 16;

	// Bus address split into block select and register offset
	localparam int cCsrOfsWidth = 8;
	localparam int cBlockWidth = 8;

	//----------------------------------------------------------------------
	// Register map
	//----------------------------------------------------------------------
	localparam logic [cCsrOfsWidth-1:0] cOfsEnable = 8'h00;
	localparam logic [cCsrOfsWidth-1:0] cOfsFlashMode = 8'h04;
	localparam logic [cCsrOfsWidth-1:0] cOfsDuty0 = 8'h08;	// Duty 0..4 at 08..18
	localparam logic [cCsrOfsWidth-1:0] cOfsIvTimer0 = 8'h1c;	// Timer 0..4 at 1c..2c
	localparam int cOfsStep = 4;	// Byte step between channel registers

	// PWM cycle length, counter runs 0..254
	localparam int cPwmPeriod = 255;

	// Flash mode codes, code 3 behaves as steady
	localparam logic [cFlashModeWidth-1:0] cModeSteady = 2'd0;
	localparam logic [cFlashModeWidth-1:0] cModeBlink = 2'd1;
	localparam logic [cFlashModeWidth-1:0] cModeAlternate = 2'd2;

	// Reset values
	localparam logic [cLedNumber-1:0] cEnableReset = '0;
	localparam logic [cFlashModeWidth-1:0] cFlashModeReset = '0;
	localparam logic [cDutyWidth-1:0] cDutyReset = '0;
	localparam logic [cIvTimerWidth-1:0] cIvTimerReset = '1;	// Slowest blink

endpackage

`default_nettype wire

// File: hw/gpioCsr.sv
//--------------------------------------------------------------------------
// GPIO control and status register block
// Decodes bus writes into LED enable, flash mode, duty and timer registers
// and returns read data with a valid pulse one cycle after a block hit
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpioCsr #(
	parameter logic [gpioPkg::cBlockWidth-1:0] pAdrsMap = 8'h01,
	parameter int pBusAdrsBit = 16
)(
	input wire iSysClk,
	input wire rstN,
	// Bus slave
	input wire [31:0] susiWd,
	input wire [pBusAdrsBit-1:0] susiAdrs,
	input wire susiWCke,
	output logic [31:0] susiRd,
	output logic susiREd,
	// Register outputs
	output logic [gpioPkg::cLedNumber-1:0] ledEn,
	output logic [gpioPkg::cFlashModeWidth-1:0] flashMode,
	output logic [gpioPkg::cDutyWidth-1:0] duty0,
	output logic [gpioPkg::cDutyWidth-1:0] duty1,
	output logic [gpioPkg::cDutyWidth-1:0] duty2,
	output logic [gpioPkg::cDutyWidth-1:0] duty3,
	output logic [gpioPkg::cDutyWidth-1:0] duty4,
	output logic [gpioPkg::cIvTimerWidth-1:0] ivTimer0,
	output logic [gpioPkg::cIvTimerWidth-1:0] ivTimer1,
	output logic [gpioPkg::cIvTimerWidth-1:0] ivTimer2,
	output logic [gpioPkg::cIvTimerWidth-1:0] ivTimer3,
	output logic [gpioPkg::cIvTimerWidth-1:0] ivTimer4
);
	import gpioPkg::*;

	logic [cCsrOfsWidth-1:0] csrOfs;
	logic blockHit;
	logic wrHit;
	logic enableWe;
	logic flashModeWe;
	logic [cLedNumber-1:0] dutyWe;
	logic [cLedNumber-1:0] ivTimerWe;
	logic [cDutyWidth-1:0] dutyReg [cLedNumber];
	logic [cIvTimerWidth-1:0] ivTimerReg [cLedNumber];
	logic [31:0] rdNext;

	//----------------------------------------------------------------------
	// Address decode
	//----------------------------------------------------------------------
	assign csrOfs = susiAdrs[cCsrOfsWidth-1:0];
	assign blockHit = (susiAdrs[cCsrOfsWidth +: cBlockWidth] == pAdrsMap);
	assign wrHit = susiWCke & blockHit;

	always_comb
	begin
		enableWe = wrHit && (csrOfs == cOfsEnable);
		flashModeWe = wrHit && (csrOfs == cOfsFlashMode);
		// One enable per channel register
		for (int i = 0; i < cLedNumber; i++)
		begin
			dutyWe[i] = wrHit && (csrOfs == cCsrOfsWidth'(cOfsDuty0 + cOfsStep * i));
			ivTimerWe[i] = wrHit && (csrOfs == cCsrOfsWidth'(cOfsIvTimer0 + cOfsStep * i));
		end
	end

	//----------------------------------------------------------------------
	// Register file
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ledEn <= cEnableReset;
			flashMode <= cFlashModeReset;
			for (int i = 0; i < cLedNumber; i++)
			begin
				dutyReg[i] <= cDutyReset;
				ivTimerReg[i] <= cIvTimerReset;
			end
		end
		else
		begin
			if (enableWe)
				ledEn <= susiWd[cLedNumber-1:0];
			if (flashModeWe)
				flashMode <= susiWd[cFlashModeWidth-1:0];
			for (int i = 0; i < cLedNumber; i++)
			begin
				if (dutyWe[i])
					dutyReg[i] <= susiWd[cDutyWidth-1:0];	// Low field bits only
				if (ivTimerWe[i])
					ivTimerReg[i] <= susiWd[cIvTimerWidth-1:0];
			end
		end
	end

	// Channel register outputs
	assign duty0 = dutyReg[0];
	assign duty1 = dutyReg[1];
	assign duty2 = dutyReg[2];
	assign duty3 = dutyReg[3];
	assign duty4 = dutyReg[4];
	assign ivTimer0 = ivTimerReg[0];
	assign ivTimer1 = ivTimerReg[1];
	assign ivTimer2 = ivTimerReg[2];
	assign ivTimer3 = ivTimerReg[3];
	assign ivTimer4 = ivTimerReg[4];

	//----------------------------------------------------------------------
	// Read path
	//----------------------------------------------------------------------
	// Unmapped offsets read as zero
	always_comb
	begin
		rdNext = '0;
		if (csrOfs == cOfsEnable)
			rdNext = 32'(ledEn);
		if (csrOfs == cOfsFlashMode)
			rdNext = 32'(flashMode);
		for (int i = 0; i < cLedNumber; i++)
		begin
			if (csrOfs == cCsrOfsWidth'(cOfsDuty0 + cOfsStep * i))
				rdNext = 32'(dutyReg[i]);
			if (csrOfs == cCsrOfsWidth'(cOfsIvTimer0 + cOfsStep * i))
				rdNext = 32'(ivTimerReg[i]);
		end
	end

	// Read data follows any hit, held otherwise
	always_ff @(posedge iSysClk)
	begin
		if (blockHit)
			susiRd <= rdNext;	// Pre-write value on a same-cycle write
	end

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			susiREd <= 1'b0;
		else
			susiREd <= blockHit;	// One-cycle valid per hit cycle
	end

endmodule

`default_nettype wire

// File: hw/gpioLedChannel.sv
//--------------------------------------------------------------------------
// GPIO LED channel
// PWM counter and interval timer with blink phase, output level chosen
// by the flash mode and registered onto the LED pin
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpioLedChannel (
	input wire iSysClk,
	input wire rstN,
	input wire enable,
	input wire [gpioPkg::cFlashModeWidth-1:0] flashMode,
	input wire [gpioPkg::cDutyWidth-1:0] duty,
	input wire [gpioPkg::cIvTimerWidth-1:0] ivTimer,
	input wire oddChannel,	// Channel position, inverts phase in alternate mode
	output logic led
);
	import gpioPkg::*;

	// Last PWM counter value before wrap
	localparam logic [cDutyWidth-1:0] cPwmLast = cDutyWidth'(cPwmPeriod - 1);

	logic chanClr;
	logic [cDutyWidth-1:0] pwmCnt;
	logic pwmLevel;
	logic [cIvTimerWidth-1:0] ivCnt;
	logic ivHit;
	logic blinkPhase;
	logic ledNext;

	// Channel held cleared while disabled
	assign chanClr = !rstN || !enable;

	//----------------------------------------------------------------------
	// PWM
	//----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (chanClr)
			pwmCnt <= '0;
		else if (pwmCnt == cPwmLast)
			pwmCnt <= '0;
		else
			pwmCnt <= pwmCnt + 1'b1;
	end

	// Duty 0 never high, duty 255 always high
	assign pwmLevel = (pwmCnt < duty);

	//----------------------------------------------------------------------
	// Interval timer and blink phase
	//----------------------------------------------------------------------
	assign ivHit = (ivCnt == ivTimer);

	always_ff @(posedge iSysClk)
	begin
		if (chanClr)
		begin
			ivCnt <= '0;
			blinkPhase <= 1'b0;
		end
		else if (ivHit)
		begin
			ivCnt <= '0;	// Phase flips every reload+1 cycles
			blinkPhase <= ~blinkPhase;
		end
		else
		begin
			ivCnt <= ivCnt + 1'b1;
		end
	end

	//----------------------------------------------------------------------
	// Output select
	//----------------------------------------------------------------------
	always_comb
	begin
		case (flashMode)
			cModeBlink:
				ledNext = pwmLevel & blinkPhase;
			cModeAlternate:
				ledNext = pwmLevel & (blinkPhase ^ oddChannel);	// Odd ones lit off-phase
			default:
				ledNext = pwmLevel;	// Steady and spare code
		endcase
	end

	// LED lags the counter state by one cycle
	always_ff @(posedge iSysClk)
	begin
		if (chanClr)
			led <= 1'b0;
		else
			led <= ledNext;
	end

endmodule

`default_nettype wire

// File: hw/gpioTop.sv
//--------------------------------------------------------------------------
// GPIO LED controller top level
// Register block on the bus driving five independent LED channels
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpioTop #(
	parameter logic [gpioPkg::cBlockWidth-1:0] pAdrsMap = 8'h01,
	parameter int pBusAdrsBit = 16
)(
	input wire iSysClk,
	input wire rstN,
	// Bus slave
	input wire [31:0] susiWd,
	input wire [pBusAdrsBit-1:0] susiAdrs,
	input wire susiWCke,
	output wire [31:0] susiRd,
	output wire susiREd,
	// LED pins
	output wire [gpioPkg::cLedNumber-1:0] led
);
	import gpioPkg::*;

	wire [cLedNumber-1:0] ledEn;
	wire [cFlashModeWidth-1:0] flashMode;
	wire [cDutyWidth-1:0] duty [cLedNumber];
	wire [cIvTimerWidth-1:0] ivTimer [cLedNumber];

	//----------------------------------------------------------------------
	// Register block
	//----------------------------------------------------------------------
	gpioCsr #(
		.pAdrsMap (pAdrsMap),
		.pBusAdrsBit (pBusAdrsBit)
	) uGpioCsr (
		.iSysClk (iSysClk),
		.rstN (rstN),
		.susiWd (susiWd),
		.susiAdrs (susiAdrs),
		.susiWCke (susiWCke),
		.susiRd (susiRd),
		.susiREd (susiREd),
		.ledEn (ledEn),
		.flashMode (flashMode),
		.duty0 (duty[0]),
		.duty1 (duty[1]),
		.duty2 (duty[2]),
		.duty3 (duty[3]),
		.duty4 (duty[4]),
		.ivTimer0 (ivTimer[0]),
		.ivTimer1 (ivTimer[1]),
		.ivTimer2 (ivTimer[2]),
		.ivTimer3 (ivTimer[3]),
		.ivTimer4 (ivTimer[4])
	);

	//----------------------------------------------------------------------
	// LED channels
	//----------------------------------------------------------------------
	for (genvar i = 0; i < cLedNumber; i++)
	begin : gLed
		gpioLedChannel uLedChannel (
			.iSysClk (iSysClk),
			.rstN (rstN),
			.enable (ledEn[i]),
			.flashMode (flashMode),	// Shared by all channels
			.duty (duty[i]),
			.ivTimer (ivTimer[i]),
			.oddChannel (1'(i % 2)),
			.led (led[i])
		);
	end

endmodule

`default_nettype wire

// File: bench/gpioTb_asserts.sv
//--------------------------------------------------------------------------
// GPIO LED controller bus and LED protocol assertions
// Bound into the top level to watch read valid, LED clearing and read data
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpioTb_asserts #(
	parameter logic [gpioPkg::cBlockWidth-1:0] pAdrsMap = 8'h01,
	parameter int pBusAdrsBit = 16
)(
	input wire iSysClk,
	input wire rstN,
	input wire [pBusAdrsBit-1:0] susiAdrs,
	input wire [31:0] susiRd,
	input wire susiREd,
	input wire [gpioPkg::cLedNumber-1:0] ledEn,
	input wire [gpioPkg::cLedNumber-1:0] led
);
	import gpioPkg::*;

	logic [cCsrOfsWidth-1:0] ofs;
	logic blockHit;
	logic dutyHit;
	int failCount = 0;

	assign ofs = susiAdrs[cCsrOfsWidth-1:0];
	assign blockHit = (susiAdrs[cCsrOfsWidth +: cBlockWidth] == pAdrsMap);
	assign dutyHit = blockHit && (ofs >= cOfsDuty0) && (ofs[1:0] == 2'b00)
		&& (ofs <= cCsrOfsWidth'(cOfsDuty0 + cOfsStep * (cLedNumber - 1)));

	// Valid pulse only after a hit
	assert property (@(posedge iSysClk) disable iff (!rstN) susiREd |-> $past(blockHit))
		else begin failCount++; $error("susiREd high without a block hit"); end

	// Disabled channel goes dark next cycle
	assert property (@(posedge iSysClk) disable iff (!rstN) (led & ~$past(ledEn)) == '0)
		else begin failCount++; $error("LED lit one cycle after enable low"); end

	assert property (@(posedge iSysClk) disable iff (!rstN)
		(susiREd && $past(dutyHit)) |-> (susiRd[31:cDutyWidth] == '0))
		else begin failCount++; $error("duty read data not zero-extended"); end

endmodule

bind gpioTop gpioTb_asserts #(
	.pAdrsMap (pAdrsMap),
	.pBusAdrsBit (pBusAdrsBit)
) uGpioTbAsserts (
	.iSysClk (iSysClk),
	.rstN (rstN),
	.susiAdrs (susiAdrs),
	.susiRd (susiRd),
	.susiREd (susiREd),
	.ledEn (ledEn),
	.led (led)
);

`default_nettype wire

// File: bench/gpioTb.sv
//--------------------------------------------------------------------------
// GPIO LED controller testbench
// Register access over the bus, then PWM, blink, alternate and enable
// behavior of the LED channels measured by counting lit cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gpioTb;
	import gpioPkg::*;

	localparam logic [7:0] cBlk = 8'h01;
	localparam logic [7:0] cForeignBlk = 8'h02;
	localparam logic [15:0] cIdleAdrs = 16'h0000;	// Block 00, never a hit
	localparam logic [7:0] cOfsUnmapped = 8'h30;
	localparam int cRegCount = 2 + 2 * cLedNumber;
	localparam int cTestCount = 8;
	localparam int cResetCycles = 4;
	localparam int cSettle = 4;
	localparam int cWriteCycles = 2;
	localparam int cOtherCycles = 400;	// Register, alternate and enable tests
	localparam int cMargin = 200;

	logic iSysClk;
	logic rstN;
	logic [31:0] susiWd;
	logic [15:0] susiAdrs;
	logic susiWCke;
	wire [31:0] susiRd;
	wire susiREd;
	wire [cLedNumber-1:0] led;

	// Stimulus table, one row per LED test
	int tabChan [cTestCount];
	int tabMode [cTestCount];
	int tabDuty [cTestCount];
	int tabReload [cTestCount];
	int tabWindow [cTestCount];
	int tabExpect [cTestCount];

	logic [31:0] rngState = 32'h225e_8336;
	int errors = 0;
	int checks = 0;
	int testNum = 0;
	int errStart = 0;
	int cycleCount = 0;
	int cycleLimit = cOtherCycles + cMargin;

	gpioTop #(
		.pAdrsMap (cBlk),
		.pBusAdrsBit (16)
	) i_gpioTop (
		.iSysClk (iSysClk),
		.rstN (rstN),
		.susiWd (susiWd),
		.susiAdrs (susiAdrs),
		.susiWCke (susiWCke),
		.susiRd (susiRd),
		.susiREd (susiREd),
		.led (led)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;
	end

	always @(posedge iSysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Register index 0 enable, 1 mode, then duties, then timers
	function automatic logic [7:0] regOffset(input int idx);
		if (idx == 0)
			return cOfsEnable;
		else if (idx == 1)
			return cOfsFlashMode;
		else if (idx < 2 + cLedNumber)
			return 8'(cOfsDuty0 + cOfsStep * (idx - 2));
		return 8'(cOfsIvTimer0 + cOfsStep * (idx - 2 - cLedNumber));
	endfunction

	function automatic logic [31:0] fieldMask(input int idx);
		if (idx == 0)
			return (32'd1 << cLedNumber) - 1;
		else if (idx == 1)
			return (32'd1 << cFlashModeWidth) - 1;
		else if (idx < 2 + cLedNumber)
			return (32'd1 << cDutyWidth) - 1;
		return (32'd1 << cIvTimerWidth) - 1;
	endfunction

	function automatic logic [31:0] resetValue(input int idx);
		return (idx >= 2 + cLedNumber) ? fieldMask(idx) : 32'd0;	// Timers reset to all ones
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic startTest();
		errStart = errors;
	endtask

	task automatic finishTest(input string name);
		testNum++;
		$display("Test %0d %s: %0d mismatches", testNum, name, errors - errStart);
	endtask

	task automatic busWrite(input logic [7:0] blk, input logic [7:0] ofs, input logic [31:0] data);
		@(posedge iSysClk);
		susiAdrs <= {blk, ofs};
		susiWd <= data;
		susiWCke <= 1'b1;
		@(posedge iSysClk);
		susiWCke <= 1'b0;
		susiAdrs <= cIdleAdrs;
	endtask

	// Data and valid sampled mid-cycle after the capture edge
	task automatic busRead(input logic [7:0] blk, input logic [7:0] ofs,
		output logic [31:0] data, output logic valid);
		@(posedge iSysClk);
		susiAdrs <= {blk, ofs};
		susiWCke <= 1'b0;
		@(posedge iSysClk);
		susiAdrs <= cIdleAdrs;
		@(negedge iSysClk);
		data = susiRd;
		valid = susiREd;
	endtask

	task automatic countLed(input int ch, input int window, output int count);
		count = 0;
		repeat (window)
		begin
			@(negedge iSysClk);
			if (led[ch])
				count++;
		end
	endtask

	task automatic addEntry(input int idx, input int ch, input int mode, input int duty,
		input int reload, input int window, input int expCount);
		tabChan[idx] = ch;
		tabMode[idx] = mode;
		tabDuty[idx] = duty;
		tabReload[idx] = reload;
		tabWindow[idx] = window;
		tabExpect[idx] = expCount;
	endtask

	//----------------------------------------------------------------------------
	// Stimulus table
	//----------------------------------------------------------------------------
	task automatic buildTable();
		int d [3];
		for (int i = 0; i < 3; i++)
		begin
			rngState = xorshift(rngState);
			d[i] = int'(rngState[7:0]);
		end
		// Steady: duty highs per 255 cycles
		addEntry(0, 0, cModeSteady, d[0], 0, 255, d[0]);
		addEntry(1, 1, cModeSteady, 0, 0, 255, 0);
		addEntry(2, 2, cModeSteady, 255, 0, 255, 255);
		addEntry(3, 3, cModeSteady, d[1], 7, 510, 2 * d[1]);
		addEntry(4, 4, 3, d[2], 0, 255, d[2]);	// Spare code acts as steady
		// Blink with full duty: m(k+1) highs in 2m(k+1)
		addEntry(5, 1, cModeBlink, 255, 3, 2 * 4 * (3 + 1), 4 * (3 + 1));
		addEntry(6, 4, cModeBlink, 255, 9, 2 * 3 * (9 + 1), 3 * (9 + 1));
		addEntry(7, 2, cModeBlink, 255, 0, 2 * 8 * (0 + 1), 8 * (0 + 1));
		cycleLimit = cResetCycles + cOtherCycles + cMargin;
		for (int t = 0; t < cTestCount; t++)
			cycleLimit += tabWindow[t] + cSettle + 5 * cWriteCycles;
	endtask

	//----------------------------------------------------------------------------
	// Tests
	//----------------------------------------------------------------------------
	task automatic checkResetState();
		int litCycles;
		logic [31:0] data;
		logic valid;
		startTest();
		litCycles = 0;
		repeat (16)
		begin
			@(negedge iSysClk);
			if (led != '0)
				litCycles++;
		end
		checkValue("led lit cycles", 32'(litCycles), 32'd0);
		for (int idx = 0; idx < cRegCount; idx++)
		begin
			busRead(cBlk, regOffset(idx), data, valid);
			checkValue("susiREd", 32'(valid), 32'd1);
			checkValue($sformatf("susiRd reg %0d", idx), data, resetValue(idx));
		end
		finishTest("reset values");
	endtask

	task automatic checkRegisterAccess();
		logic [31:0] wrVal [cRegCount];
		logic [31:0] data;
		logic valid;
		startTest();
		for (int idx = 0; idx < cRegCount; idx++)
		begin
			rngState = xorshift(rngState);
			wrVal[idx] = rngState;
			busWrite(cBlk, regOffset(idx), wrVal[idx]);
		end
		for (int idx = 0; idx < cRegCount; idx++)
		begin
			busRead(cBlk, regOffset(idx), data, valid);
			checkValue("susiREd", 32'(valid), 32'd1);
			checkValue($sformatf("susiRd reg %0d", idx), data, wrVal[idx] & fieldMask(idx));
		end
		// Foreign block writes must not land
		for (int idx = 0; idx < cRegCount; idx++)
		begin
			rngState = xorshift(rngState);
			busWrite(cForeignBlk, regOffset(idx), rngState);
		end
		busRead(cForeignBlk, cOfsEnable, data, valid);
		checkValue("susiREd foreign", 32'(valid), 32'd0);
		for (int idx = 0; idx < cRegCount; idx++)
		begin
			busRead(cBlk, regOffset(idx), data, valid);
			checkValue($sformatf("susiRd reg %0d kept", idx), data, wrVal[idx] & fieldMask(idx));
		end
		busRead(cBlk, cOfsUnmapped, data, valid);
		checkValue("susiREd unmapped", 32'(valid), 32'd1);
		checkValue("susiRd unmapped", data, 32'd0);
		finishTest("register access");
	endtask

	task automatic runTableTest(input int t);
		int count;
		int ch;
		startTest();
		ch = tabChan[t];
		busWrite(cBlk, cOfsEnable, 32'd0);	// Restart channel from a clean state
		busWrite(cBlk, cOfsFlashMode, 32'(tabMode[t]));
		busWrite(cBlk, regOffset(2 + ch), 32'(tabDuty[t]));
		busWrite(cBlk, regOffset(2 + cLedNumber + ch), 32'(tabReload[t]));
		busWrite(cBlk, cOfsEnable, 32'd1 << ch);
		repeat (cSettle) @(posedge iSysClk);
		countLed(ch, tabWindow[t], count);
		checkValue($sformatf("led[%0d] high count", ch), 32'(count), 32'(tabExpect[t]));
		finishTest($sformatf("mode %0d ch %0d duty %0d", tabMode[t], ch, tabDuty[t]));
	endtask

	task automatic checkAlternate();
		int even;
		int odd;
		int both;
		startTest();
		busWrite(cBlk, cOfsEnable, 32'd0);
		busWrite(cBlk, cOfsFlashMode, 32'(cModeAlternate));
		for (int ch = 0; ch < 2; ch++)
		begin
			busWrite(cBlk, regOffset(2 + ch), 32'd255);
			busWrite(cBlk, regOffset(2 + cLedNumber + ch), 32'd4);
		end
		busWrite(cBlk, cOfsEnable, 32'b00011);
		repeat (cSettle) @(posedge iSysClk);
		even = 0;
		odd = 0;
		both = 0;
		repeat (2 * 3 * (4 + 1))
		begin
			@(negedge iSysClk);
			even += int'(led[0]);
			odd += int'(led[1]);
			both += int'(led[0] & led[1]);
		end
		checkValue("led[0] high count", 32'(even), 32'(3 * (4 + 1)));
		checkValue("led[1] high count", 32'(odd), 32'(3 * (4 + 1)));
		checkValue("led[0] and led[1] overlap", 32'(both), 32'd0);
		finishTest("alternate pair");
	endtask

	task automatic checkEnableClear();
		int match;
		startTest();
		busWrite(cBlk, cOfsFlashMode, 32'(cModeSteady));
		for (int ch = 0; ch < cLedNumber; ch++)
			busWrite(cBlk, regOffset(2 + ch), 32'd255);
		busWrite(cBlk, cOfsEnable, 32'b11111);
		repeat (cSettle) @(posedge iSysClk);
		@(negedge iSysClk);
		checkValue("led all on", 32'(led), 32'b11111);
		busWrite(cBlk, cOfsEnable, 32'b11011);
		@(posedge iSysClk);	// Cleared LED drops one cycle after its enable
		match = 0;
		repeat (20)
		begin
			@(negedge iSysClk);
			if (led == 5'b11011)
				match++;
		end
		checkValue("led pattern cycles", 32'(match), 32'd20);
		finishTest("enable clear");
	endtask

	//----------------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------------
	initial
	begin
		int assertFails;
		rstN = 1'b0;
		susiWd = '0;
		susiAdrs = cIdleAdrs;
		susiWCke = 1'b0;
		buildTable();
		repeat (cResetCycles) @(posedge iSysClk);
		rstN <= 1'b1;
		checkResetState();
		checkRegisterAccess();
		for (int t = 0; t < cTestCount; t++)
			runTableTest(t);
		checkAlternate();
		checkEnableClear();
		assertFails = i_gpioTop.uGpioTbAsserts.failCount;
		if (assertFails != 0)
			$display("Assertions fired %0d times during the run", assertFails);
		errors += assertFails;
		$display("Summary: %0d tests, %0d checks, %0d errors", testNum, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hw/gpioPkg.sv
hw/gpioCsr.sv
hw/gpioLedChannel.sv
hw/gpioTop.sv
bench/gpioTb_asserts.sv
bench/gpioTb.sv

// File: Makefile
# Verilator simulation of the GPIO LED controller
VERILATOR ?= verilator
TOP ?= gpioTb
FILELIST ?= list.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -Wno-fatal
SIMARGS ?= +verilator+error+limit+100
FAILMSG ?= Verification failed
PASSMSG ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
